// ==== vlog.f ====
hw/RetPkg.sv
hw/RetPredTable.sv
hw/RetAddrStack.sv
hw/RetRecoveryQueue.sv
hw/RetStackCtrl.sv
hw/ReturnPredictor.sv
sim/ClockGen.sv
sim/ReturnPredictorTb.sv

// ==== Makefile ====
# Verilator build and run for the return-address predictor

VERILATOR ?= verilator
TOP ?= ReturnPredictorTb
BUILD ?= obj_dir
FILELIST ?= vlog.f
VFLAGS ?= --binary --timing

SIM := $(BUILD)/V$(TOP)
SRCS := $(shell cat $(FILELIST))
PASS_MSG := Result: PASSED

.PHONY: all run check clean

all: $(SIM)

$(SIM): $(FILELIST) $(SRCS) sim/ret_trace.txt
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)

run: $(SIM)
	./$(SIM)

check: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(BUILD)

// ==== sim/ret_trace.txt ====
# fv pc bv boff call fid cfid set ridx mfid dv daddr didx dcall dret dclean dcompr rnd
#   then expected: predValid predOffs predCompr curRetAddr stall curIdx (all hex)
T reset
1 00000123 0 0 0 00 00 0 0 00 0 00000000 0 0 0 0 0 0  0 0 0 00000000 0 0
1 00004567 0 0 0 01 00 0 0 00 0 00000000 0 0 0 0 0 0  0 0 0 00000000 0 0
T fetch_call
1 00000100 1 5 1 01 00 0 0 00 0 00000000 0 0 0 0 0 0  0 0 0 00000000 0 0
0 00000000 0 0 0 00 00 0 0 00 0 00000000 0 0 0 0 0 0  0 0 0 00000106 0 1
T train_and_pop
0 00000000 0 0 0 00 00 0 0 00 1 00000203 1 0 1 0 1 0  0 0 0 00000106 0 1
1 00000200 0 0 0 02 00 0 0 00 0 00000000 0 0 0 0 0 1  1 3 1 00000106 0 1
0 00000000 0 0 0 00 00 0 0 00 0 00000000 0 0 0 0 0 0  0 0 0 00000000 0 0
T clean_and_age
0 00000000 0 0 0 00 00 0 0 00 1 00000203 0 0 0 1 0 0  0 0 0 00000000 0 0
1 00000200 0 0 0 03 00 0 0 00 0 00000000 0 0 0 0 0 0  0 0 0 00000000 0 0
0 00000000 0 0 0 00 00 0 0 00 1 00002203 0 0 1 0 1 0  0 0 0 00000000 0 0
0 00000000 0 0 0 00 00 0 0 00 1 00004203 0 0 1 0 1 0  0 0 0 00000000 0 0
0 00000000 0 0 0 00 00 0 0 00 1 00006203 0 0 1 0 1 0  0 0 0 00000000 0 0
0 00000000 0 0 0 00 00 0 0 00 1 00008205 0 0 1 0 0 0  0 0 0 00000000 0 0
1 00006200 1 0 0 04 00 0 0 00 0 00000000 0 0 0 0 0 0  0 0 0 00000000 0 0
1 00008200 1 2 0 05 00 0 0 00 0 00000000 0 0 0 0 0 1  1 5 0 00000000 0 0
T mispredict_recovery
1 00000300 1 1 1 06 00 0 0 00 0 00000000 0 0 0 0 0 0  0 0 0 00000000 0 0
1 00000400 1 2 1 07 00 0 0 00 0 00000000 0 0 0 0 0 0  0 0 0 00000302 0 1
1 00004200 0 0 0 08 00 0 0 00 0 00000000 0 0 0 0 0 1  1 3 1 00000403 0 2
1 00004200 0 0 0 09 00 0 0 00 0 00000000 0 0 0 0 0 1  1 3 1 00000302 0 1
0 00000000 0 0 0 00 00 1 2 09 0 00000000 0 0 0 0 0 0  0 0 0 00000000 0 0
0 00000000 0 0 0 00 00 0 0 00 0 00000000 0 0 0 0 0 0  0 0 0 00000403 1 2
0 00000000 0 0 0 00 00 0 0 00 0 00000000 0 0 0 0 0 0  0 0 0 00000403 1 2
0 00000000 0 0 0 00 00 0 0 00 0 00000000 0 0 0 0 0 0  0 0 0 00000403 1 2
0 00000000 0 0 0 00 00 0 0 00 0 00000000 0 0 0 0 0 0  0 0 0 00000403 0 2
1 00004200 0 0 0 0a 00 0 0 00 0 00000000 0 0 0 0 0 1  1 3 1 00000403 0 2
0 00000000 0 0 0 00 00 0 0 00 0 00000000 0 0 0 0 0 0  0 0 0 00000302 0 1
T commit_retire
0 00000000 0 0 0 00 0c 0 0 00 0 00000000 0 0 0 0 0 0  0 0 0 00000302 0 1
0 00000000 0 0 0 00 0c 0 0 00 0 00000000 0 0 0 0 0 0  0 0 0 00000302 0 1
0 00000000 0 0 0 00 0c 0 0 00 0 00000000 0 0 0 0 0 0  0 0 0 00000302 0 1
0 00000000 0 0 0 00 0c 0 0 00 0 00000000 0 0 0 0 0 0  0 0 0 00000302 0 1
0 00000000 0 0 0 00 0c 1 1 0b 0 00000000 0 0 0 0 0 0  0 0 0 00000302 0 1
0 00000000 0 0 0 00 0c 0 0 00 0 00000000 0 0 0 0 0 0  0 0 0 00000302 1 1
0 00000000 0 0 0 00 0c 0 0 00 0 00000000 0 0 0 0 0 0  0 0 0 00000302 0 1

// ==== sim/ReturnPredictorTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ReturnPredictorTb;
    import RetPkg::*;

    localparam int StackDepth = 4;
    localparam int IdxW = $clog2(StackDepth);
    localparam int NumCols = 24;

    logic clk;
    logic rst;
    logic fetchValid;
    logic [AddrW-1:0] pc;
    logic brValid;
    FetchOff brOffs;
    logic isCall;
    FetchId fetchId;
    FetchId comFetchId;
    logic setIdx;
    logic [IdxW-1:0] restoreIdx;
    FetchId misprFetchId;
    ReturnDecUpdate decUpd;
    PredBranch predBr;
    logic [AddrW-1:0] curRetAddr;
    logic [IdxW-1:0] curIdx;
    logic stall;

    string lines[$];
    string testName = "";
    logic traceLoaded = 1'b0;
    int seed;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int testErrs = 0;
    int testChecks = 0;

    ClockGen #(.Period(20), .ResetCycles(8)) clkGen (.clk(clk), .rst(rst));

    ReturnPredictor #(
        .StackDepth(StackDepth),
        .QueueDepth(4),
        .TableSets(16),
        .TableWays(2),
        .TagW(10)
    ) uut (
        .clk(clk), .rst(rst),
        .fetchValid(fetchValid), .pc(pc), .brValid(brValid), .brOffs(brOffs),
        .isCall(isCall), .fetchId(fetchId), .comFetchId(comFetchId),
        .setIdx(setIdx), .restoreIdx(restoreIdx), .misprFetchId(misprFetchId),
        .decUpd(decUpd),
        .predBr(predBr), .curRetAddr(curRetAddr), .curIdx(curIdx), .stall(stall)
    );

    function automatic void noteResult(input logic ok);
        checks++;
        testChecks++;
        if (!ok) begin
            errors++;
            testErrs++;
        end
    endfunction

    task automatic checkPred(input PredBranch exp, input PredBranch got);
        noteResult(got === exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t predBr expected %h got %h", $time, exp, got);
        end
    endtask

    task automatic checkAddr(input string name, input logic [AddrW-1:0] exp,
            input logic [AddrW-1:0] got);
        noteResult(got === exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic checkIdx(input logic [IdxW-1:0] exp, input logic [IdxW-1:0] got);
        noteResult(got === exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t curIdx expected %h got %h", $time, exp, got);
        end
    endtask

    task automatic checkFlag(input string name, input logic exp, input logic got);
        noteResult(got === exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s expected %b got %b", $time, name, exp, got);
        end
    endtask

    task automatic closeTest();
        if (testName != "") begin
            tests++;
            $display("test %s: %0d checks, %0d errors", testName, testChecks, testErrs);
        end
    endtask

    // Columns 0..17 are inputs, 18..23 expected pred valid/offs/compr, ret, stall, idx
    task automatic runCycle(input string line);
        logic [31:0] f [NumCols];
        logic [31:0] rnd;
        PredBranch expPred;
        int n;
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11],
            f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21], f[22], f[23]);
        if (n != NumCols) begin
            errors++;
            testErrs++;
            $display("Trace line could not be parsed: %s", line);
        end else begin
            @(negedge clk);
            fetchValid = f[0][0];
            pc = f[1][AddrW-1:0];
            if (f[17][0]) begin
                // Bits above the tag fold never reach the hash
                rnd = $random(seed);
                pc[AddrW-1:23] = rnd[7:0];
            end
            brValid = f[2][0];
            brOffs = f[3][FetchOffW-1:0];
            isCall = f[4][0];
            fetchId = f[5][4:0];
            comFetchId = f[6][4:0];
            setIdx = f[7][0];
            restoreIdx = f[8][IdxW-1:0];
            misprFetchId = f[9][4:0];
            decUpd.valid = f[10][0];
            decUpd.addr = f[11][AddrW-1:0];
            decUpd.idx = f[12][3:0];
            decUpd.isCall = f[13][0];
            decUpd.isRet = f[14][0];
            decUpd.cleanRet = f[15][0];
            decUpd.compr = f[16][0];
            // Prediction target is always the current stack top
            expPred.dst = f[21][AddrW-1:0];
            expPred.offs = f[19][FetchOffW-1:0];
            expPred.compr = f[20][0];
            expPred.valid = f[18][0];
            #8;
            checkPred(expPred, predBr);
            checkAddr("curRetAddr", f[21][AddrW-1:0], curRetAddr);
            checkFlag("stall", f[22][0], stall);
            checkIdx(f[23][IdxW-1:0], curIdx);
        end
    endtask

    initial begin
        int fd;
        string line;
        fetchValid = 1'b0;
        pc = '0;
        brValid = 1'b0;
        brOffs = '0;
        isCall = 1'b0;
        fetchId = '0;
        comFetchId = '0;
        setIdx = 1'b0;
        restoreIdx = '0;
        misprFetchId = '0;
        decUpd = '0;
        seed = 32'ha91c_4f6a;
        fd = $fopen("sim/ret_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file sim/ret_trace.txt");
            $display("Result: FAILED");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) != 0) begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
            traceLoaded = 1'b1;
            do begin
                @(negedge clk);
            end while (rst);
            foreach (lines[i]) begin
                if (lines[i].len() < 2 || lines[i].getc(0) == "#") begin
                    continue;
                end
                if (lines[i].getc(0) == "T") begin
                    closeTest();
                    startTest(lines[i]);
                end else begin
                    runCycle(lines[i]);
                end
            end
            closeTest();
            $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
            if (errors == 0) begin
                $display("Result: PASSED");
            end else begin
                $display("Result: FAILED");
            end
            $finish;
        end
    end

    // Starts a new test from its name line
    task automatic startTest(input string line);
        int n;
        n = $sscanf(line, "T %s", testName);
        testChecks = 0;
        testErrs = 0;
        if (n != 1) begin
            testName = "unnamed";
        end
    endtask

    // Two clock periods per trace line plus the reset phase
    initial begin
        longint limit;
        wait (traceLoaded);
        limit = longint'(lines.size()) * 40 + 8 * 20;
        #(limit);
        $display("Timeout: the trace did not finish in the allowed time");
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/ClockGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module ClockGen #(
    parameter int Period = 20,
    parameter int ResetCycles = 8
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(Period / 2) clk = ~clk;
    end

    // Reset held for a fixed number of rising edges
    initial begin
        rst = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== hw/ReturnPredictor.sv ====
`timescale 1ns/1ps
`default_nettype none

module ReturnPredictor #(
    parameter int StackDepth = 4,
    parameter int QueueDepth = 4,
    parameter int TableSets = 16,
    parameter int TableWays = 2,
    parameter int TagW = 10,
    localparam int StackIdxW = $clog2(StackDepth)
) (
    input wire clk,
    input wire rst,
    input wire fetchValid,
    input wire [RetPkg::AddrW-1:0] pc,
    input wire brValid,
    input wire RetPkg::FetchOff brOffs,
    input wire isCall,
    input wire RetPkg::FetchId fetchId,
    input wire RetPkg::FetchId comFetchId,
    input wire setIdx,
    input wire [StackIdxW-1:0] restoreIdx,
    input wire RetPkg::FetchId misprFetchId,
    input wire RetPkg::ReturnDecUpdate decUpd,
    output RetPkg::PredBranch predBr,
    output logic [RetPkg::AddrW-1:0] curRetAddr,
    output logic [StackIdxW-1:0] curIdx,
    output logic stall
);
    import RetPkg::*;

    logic lookupEn;
    logic hit;
    FetchOff hitOffs;
    logic hitCompr;
    logic [$clog2(TableWays)-1:0] hitWay;
    logic [TableWays-1:0] touch;
    logic insert;
    logic invalidate;

    logic [AddrW-1:0] stackTop;
    logic wrEn;
    logic [StackIdxW-1:0] wrIdx;
    logic [AddrW-1:0] wrAddr;
    logic decWrEn;
    logic [StackIdxW-1:0] decWrIdx;
    logic [AddrW-1:0] decWrAddr;
    logic restoreEn;
    logic [StackIdxW-1:0] restoreWrIdx;
    logic [AddrW-1:0] restoreAddr;

    logic push;
    RecEntry pushEntry;
    logic popTail;
    logic retireHead;
    RecEntry tailEntry;
    RecEntry headEntry;
    logic empty;

    assign curRetAddr = stackTop;

    RetStackCtrl #(
        .StackIdxW(StackIdxW),
        .TableWays(TableWays)
    ) ctrl (
        .clk(clk), .rst(rst),
        .fetchValid(fetchValid), .pc(pc), .brValid(brValid), .brOffs(brOffs),
        .isCall(isCall), .fetchId(fetchId), .comFetchId(comFetchId),
        .setIdx(setIdx), .restoreIdx(restoreIdx), .misprFetchId(misprFetchId),
        .decUpd(decUpd),
        .hit(hit), .hitOffs(hitOffs), .hitCompr(hitCompr), .hitWay(hitWay),
        .stackTop(stackTop),
        .tailEntry(tailEntry), .headEntry(headEntry), .empty(empty),
        .lookupEn(lookupEn), .insert(insert), .invalidate(invalidate), .touch(touch),
        .wrEn(wrEn), .wrIdx(wrIdx), .wrAddr(wrAddr),
        .decWrEn(decWrEn), .decWrIdx(decWrIdx), .decWrAddr(decWrAddr),
        .restoreEn(restoreEn), .restoreWrIdx(restoreWrIdx), .restoreAddr(restoreAddr),
        .push(push), .pushEntry(pushEntry), .popTail(popTail), .retireHead(retireHead),
        .predBr(predBr), .curIdx(curIdx), .stall(stall)
    );

    RetPredTable #(
        .TableSets(TableSets),
        .TableWays(TableWays),
        .TagW(TagW)
    ) table0 (
        .clk(clk), .rst(rst),
        .lookupPc(pc), .lookupEn(lookupEn),
        .hit(hit), .hitOffs(hitOffs), .hitCompr(hitCompr), .hitWay(hitWay),
        .touch(touch),
        .updPc(decUpd.addr), .insert(insert), .invalidate(invalidate),
        .compr(decUpd.compr)
    );

    RetAddrStack #(
        .StackDepth(StackDepth),
        .StackIdxW(StackIdxW)
    ) stack (
        .clk(clk), .rst(rst),
        .rdIdx(curIdx), .rdAddr(stackTop),
        .fetchWrEn(wrEn), .fetchWrIdx(wrIdx), .fetchWrAddr(wrAddr),
        .decWrEn(decWrEn), .decWrIdx(decWrIdx), .decWrAddr(decWrAddr),
        .restoreEn(restoreEn), .restoreIdx(restoreWrIdx), .restoreAddr(restoreAddr)
    );

    RetRecoveryQueue #(
        .QueueDepth(QueueDepth)
    ) recQueue (
        .clk(clk), .rst(rst),
        .push(push), .pushEntry(pushEntry),
        .popTail(popTail), .retireHead(retireHead),
        .tailEntry(tailEntry), .headEntry(headEntry), .empty(empty)
    );

endmodule

`default_nettype wire

// ==== hw/RetStackCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module RetStackCtrl #(
    parameter int StackIdxW = 2,
    parameter int TableWays = 2
) (
    input wire clk,
    input wire rst,
    input wire fetchValid,
    input wire [RetPkg::AddrW-1:0] pc,
    input wire brValid,
    input wire RetPkg::FetchOff brOffs,
    input wire isCall,
    input wire RetPkg::FetchId fetchId,
    input wire RetPkg::FetchId comFetchId,
    input wire setIdx,
    input wire [StackIdxW-1:0] restoreIdx,
    input wire RetPkg::FetchId misprFetchId,
    input wire RetPkg::ReturnDecUpdate decUpd,
    input wire hit,
    input wire RetPkg::FetchOff hitOffs,
    input wire hitCompr,
    input wire [$clog2(TableWays)-1:0] hitWay,
    input wire [RetPkg::AddrW-1:0] stackTop,
    input wire RetPkg::RecEntry tailEntry,
    input wire RetPkg::RecEntry headEntry,
    input wire empty,
    output logic lookupEn,
    output logic insert,
    output logic invalidate,
    output logic [TableWays-1:0] touch,
    output logic wrEn,
    output logic [StackIdxW-1:0] wrIdx,
    output logic [RetPkg::AddrW-1:0] wrAddr,
    output logic decWrEn,
    output logic [StackIdxW-1:0] decWrIdx,
    output logic [RetPkg::AddrW-1:0] decWrAddr,
    output logic restoreEn,
    output logic [StackIdxW-1:0] restoreWrIdx,
    output logic [RetPkg::AddrW-1:0] restoreAddr,
    output logic push,
    output RetPkg::RecEntry pushEntry,
    output logic popTail,
    output logic retireHead,
    output RetPkg::PredBranch predBr,
    output logic [StackIdxW-1:0] curIdx,
    output logic stall
);
    import RetPkg::*;

    logic [StackIdxW-1:0] idxQ;
    logic recovQ;
    FetchId recovId;
    FetchId recovBase;
    FetchId comBase;
    logic decActive;
    logic popTaken;
    logic pushTaken;
    logic retireScan;

    // Fetch IDs have no wrap bit, so ages are taken against a base
    FetchId tailAge;
    FetchId recovAge;
    FetchId headAge;
    FetchId comAge;

    assign curIdx = idxQ;
    assign stall = recovQ;

    assign predBr.dst = stackTop;
    assign predBr.offs = hitOffs;
    assign predBr.compr = hitCompr;
    assign predBr.valid = hit;

    // Decode corrections take precedence over fetch
    assign lookupEn = fetchValid && !setIdx;
    assign decActive = decUpd.valid;
    assign popTaken = !decActive && hit && (!brValid || brOffs >= hitOffs);
    assign pushTaken = !decActive && lookupEn && !popTaken && brValid && isCall;

    assign invalidate = decActive && decUpd.cleanRet;
    assign decWrEn = decActive && !decUpd.cleanRet && decUpd.isCall;
    assign insert = decActive && !decUpd.cleanRet && !decUpd.isCall && decUpd.isRet;
    assign decWrIdx = decUpd.idx[StackIdxW-1:0] + 1'b1;
    assign decWrAddr = decUpd.addr + 1'b1;

    always_comb begin
        touch = '0;
        if (popTaken) begin
            touch[hitWay] = 1'b1;
        end
    end

    // Call pushes the return address right after the call instruction
    assign wrEn = pushTaken;
    assign wrIdx = idxQ + 1'b1;
    assign wrAddr = {pc[AddrW-1:FetchOffW], brOffs} + 1'b1;

    assign push = popTaken;
    assign pushEntry.addr = stackTop;
    assign pushEntry.idx = StackIdxField'(idxQ);
    assign pushEntry.fetchId = fetchId + 1'b1;

    assign tailAge = tailEntry.fetchId - recovBase;
    assign recovAge = recovId - recovBase;
    assign headAge = headEntry.fetchId - comBase;
    assign comAge = comFetchId - comBase;

    // Restore newest backups until one predates the mispredict
    assign restoreEn = recovQ && !setIdx && !empty && tailAge >= recovAge;
    assign popTail = restoreEn;
    assign restoreWrIdx = tailEntry.idx[StackIdxW-1:0];
    assign restoreAddr = tailEntry.addr;

    assign retireScan = !recovQ && !setIdx && comFetchId != comBase;
    assign retireHead = retireScan && !empty && headAge < comAge;

    always_ff @(posedge clk) begin
        if (rst) begin
            idxQ <= '0;
            recovQ <= 1'b0;
            comBase <= '0;
        end else begin
            if (setIdx) begin
                idxQ <= restoreIdx;
            end else if (popTaken) begin
                idxQ <= idxQ - 1'b1;
            end else if (pushTaken) begin
                idxQ <= idxQ + 1'b1;
            end

            if (setIdx) begin
                recovQ <= 1'b1;
            end else if (recovQ && !restoreEn) begin
                recovQ <= 1'b0;
            end

            // No older backup left, skip straight to the commit point
            if (retireHead) begin
                comBase <= headEntry.fetchId;
            end else if (retireScan) begin
                comBase <= comFetchId;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (setIdx) begin
            recovId <= misprFetchId;
            recovBase <= comBase;
        end
    end

endmodule

`default_nettype wire

// ==== hw/RetRecoveryQueue.sv ====
`timescale 1ns/1ps
`default_nettype none

module RetRecoveryQueue #(
    parameter int QueueDepth = 4
) (
    input wire clk,
    input wire rst,
    input wire push,
    input wire RetPkg::RecEntry pushEntry,
    input wire popTail,
    input wire retireHead,
    output RetPkg::RecEntry tailEntry,
    output RetPkg::RecEntry headEntry,
    output logic empty
);
    import RetPkg::*;

    localparam int PtrW = $clog2(QueueDepth);
    localparam int CntW = $clog2(QueueDepth + 1);

    RecEntry mem [QueueDepth];

    // Tail is the next free slot, head the oldest backup
    logic [PtrW-1:0] tailPtr;
    logic [PtrW-1:0] headPtr;
    logic [PtrW-1:0] lastPtr;
    logic [CntW-1:0] count;
    logic full;
    logic doRetire;

    assign lastPtr = tailPtr - 1'b1;
    assign empty = count == '0;
    assign full = count == CntW'(QueueDepth);
    assign doRetire = retireHead && !empty;

    assign tailEntry = mem[lastPtr];
    assign headEntry = mem[headPtr];

    always_ff @(posedge clk) begin
        if (rst) begin
            tailPtr <= '0;
            headPtr <= '0;
            count <= '0;
        end else if (popTail && !empty) begin
            // Only happens during recovery, never together with push or retire
            tailPtr <= lastPtr;
            count <= count - 1'b1;
        end else begin
            if (push) begin
                tailPtr <= tailPtr + 1'b1;
            end
            // A push into a full queue drops the oldest entry
            if (doRetire || (push && full)) begin
                headPtr <= headPtr + 1'b1;
            end
            if (push && !doRetire && !full) begin
                count <= count + 1'b1;
            end else if (doRetire && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push && !(popTail && !empty)) begin
            mem[tailPtr] <= pushEntry;
        end
    end

endmodule

`default_nettype wire

// ==== hw/RetAddrStack.sv ====
`timescale 1ns/1ps
`default_nettype none

module RetAddrStack #(
    parameter int StackDepth = 4,
    parameter int StackIdxW = 2
) (
    input wire clk,
    input wire rst,
    input wire [StackIdxW-1:0] rdIdx,
    output logic [RetPkg::AddrW-1:0] rdAddr,
    input wire fetchWrEn,
    input wire [StackIdxW-1:0] fetchWrIdx,
    input wire [RetPkg::AddrW-1:0] fetchWrAddr,
    input wire decWrEn,
    input wire [StackIdxW-1:0] decWrIdx,
    input wire [RetPkg::AddrW-1:0] decWrAddr,
    input wire restoreEn,
    input wire [StackIdxW-1:0] restoreIdx,
    input wire [RetPkg::AddrW-1:0] restoreAddr
);
    import RetPkg::*;

    // Index wraps around the power-of-two depth
    logic [AddrW-1:0] mem [StackDepth];

    assign rdAddr = mem[rdIdx];

    // Restore beats decode, decode beats fetch
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < StackDepth; i++) begin
                mem[i] <= '0;
            end
        end else if (restoreEn) begin
            mem[restoreIdx] <= restoreAddr;
        end else if (decWrEn) begin
            mem[decWrIdx] <= decWrAddr;
        end else if (fetchWrEn) begin
            mem[fetchWrIdx] <= fetchWrAddr;
        end
    end

endmodule

`default_nettype wire

// ==== hw/RetPredTable.sv ====
`timescale 1ns/1ps
`default_nettype none

module RetPredTable #(
    parameter int TableSets = 16,
    parameter int TableWays = 2,
    parameter int TagW = 10
) (
    input wire clk,
    input wire rst,
    input wire [RetPkg::AddrW-1:0] lookupPc,
    input wire lookupEn,
    output logic hit,
    output RetPkg::FetchOff hitOffs,
    output logic hitCompr,
    output logic [$clog2(TableWays)-1:0] hitWay,
    input wire [TableWays-1:0] touch,
    input wire [RetPkg::AddrW-1:0] updPc,
    input wire insert,
    input wire invalidate,
    input wire compr
);
    import RetPkg::*;

    localparam int SetW = $clog2(TableSets);
    localparam int WayW = $clog2(TableWays);

    typedef struct packed {
        logic [TagW-1:0] tag;
        FetchOff offs;
        logic compr;
    } TableEntry;

    TableEntry entries [TableSets][TableWays];
    logic [TableWays-1:0] validQ [TableSets];
    logic [TableWays-1:0] usedQ [TableSets];

    logic [SetW-1:0] lkSet;
    logic [SetW-1:0] updSet;
    logic [TagW-1:0] lkTag;
    logic [TagW-1:0] updTag;
    logic freeFound;
    logic [WayW-1:0] freeWay;

    // XOR folding of the block address
    function automatic logic [SetW-1:0] setOf(input logic [AddrW-1:0] a);
        return a[FetchOffW +: SetW] ^ a[FetchOffW + 3 +: SetW];
    endfunction

    function automatic logic [TagW-1:0] tagOf(input logic [AddrW-1:0] a);
        return a[FetchOffW +: TagW] ^ a[FetchOffW + TagW +: TagW];
    endfunction

    assign lkSet = setOf(lookupPc);
    assign lkTag = tagOf(lookupPc);
    assign updSet = setOf(updPc);
    assign updTag = tagOf(updPc);

    // First return at or after the fetch offset wins
    always_comb begin
        hit = 1'b0;
        hitOffs = '0;
        hitCompr = 1'b0;
        hitWay = '0;
        for (int w = 0; w < TableWays; w++) begin
            if (lookupEn && validQ[lkSet][w] && entries[lkSet][w].tag == lkTag &&
                    entries[lkSet][w].offs >= lookupPc[FetchOffW-1:0] &&
                    (!hit || entries[lkSet][w].offs < hitOffs)) begin
                hit = 1'b1;
                hitOffs = entries[lkSet][w].offs;
                hitCompr = entries[lkSet][w].compr;
                hitWay = WayW'(w);
            end
        end
    end

    // Invalid or not recently used ways can be replaced
    always_comb begin
        freeFound = 1'b0;
        freeWay = '0;
        for (int w = 0; w < TableWays; w++) begin
            if (!freeFound && (!validQ[updSet][w] || !usedQ[updSet][w])) begin
                freeFound = 1'b1;
                freeWay = WayW'(w);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < TableSets; s++) begin
                validQ[s] <= '0;
                usedQ[s] <= '0;
            end
        end else if (invalidate) begin
            for (int w = 0; w < TableWays; w++) begin
                if (entries[updSet][w].tag == updTag) begin
                    validQ[updSet][w] <= 1'b0;
                end
            end
        end else if (insert) begin
            if (freeFound) begin
                validQ[updSet][freeWay] <= 1'b1;
                usedQ[updSet][freeWay] <= 1'b1;
            end else begin
                // Set is full of live entries, age it instead
                usedQ[updSet] <= '0;
            end
        end else begin
            usedQ[lkSet] <= usedQ[lkSet] | touch;
        end
    end

    always_ff @(posedge clk) begin
        if (insert && !invalidate && freeFound) begin
            entries[updSet][freeWay].tag <= updTag;
            entries[updSet][freeWay].offs <= updPc[FetchOffW-1:0];
            entries[updSet][freeWay].compr <= compr;
        end
    end

endmodule

`default_nettype wire

// ==== hw/RetPkg.sv ====
`default_nettype none

package RetPkg;

    // Halfword-granular code address
    localparam int AddrW = 31;

    // Halfword offset inside a fetch block
    localparam int FetchOffW = 3;

    localparam int FetchIdW = 5;

    // Stack index field carried in structs, wide enough for up to 16 entries
    localparam int IdxFieldW = 4;

    // Modular, only ordered relative to a base
    typedef logic [FetchIdW-1:0] FetchId;

    typedef logic [FetchOffW-1:0] FetchOff;

    typedef logic [IdxFieldW-1:0] StackIdxField;

    // Prediction handed to fetch
    typedef struct packed {
        logic [AddrW-1:0] dst;
        FetchOff offs;
        logic compr;
        logic valid;
    } PredBranch;

    // Correction coming back from decode
    typedef struct packed {
        logic valid;
        logic [AddrW-1:0] addr;
        StackIdxField idx;
        logic isCall;
        logic isRet;
        logic cleanRet;
        logic compr;
    } ReturnDecUpdate;

    // Backup of one popped stack entry
    typedef struct packed {
        logic [AddrW-1:0] addr;
        StackIdxField idx;
        FetchId fetchId;
    } RecEntry;

endpackage

`default_nettype wire
